//--- hw/dvi_pkg.sv
// video timing and pixel widths shared by the dvi output stage
// timing is kept tiny so a whole frame fits in a short simulation

`default_nettype none

package dvi_pkg;

  // horizontal timing in pixel clocks, line order is active, front porch, sync, back porch
  localparam int H_ACTIVE = 8;
  localparam int H_FP     = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BP     = 3;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP; // 16

  // vertical timing in lines, same order as a line
  localparam int V_ACTIVE = 4;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP; // 8

  // sync windows, start inclusive and end exclusive
  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  // two pixels per frame-buffer word
  localparam int WORDS_PER_FRAME = (H_ACTIVE / 2) * V_ACTIVE; // 16
  localparam int ADDR_W          = 4;

  // word layout is two 24-bit rgb pixels at bits 23:0 and 55:32
  localparam int WORD_W  = 64;
  localparam int COLOR_W = 8;

  // 12 pins, each carries two bits per pixel clock
  localparam int PIN_W = 12;

endpackage

`default_nettype wire

//--- hw/dvi_timing_ctrl.sv
// pixel and line counters with registered sync, border and frame-buffer fetch strobes
// word_req leads the even active pixel slot it fetches for by one cycle

`timescale 1ns/1ps
`default_nettype none

module dvi_timing_ctrl import dvi_pkg::*; (
  input  wire               clock,
  input  wire               rst_n,
  output logic              hs,
  output logic              vs,
  output logic              border,
  output logic              offset,
  output logic              word_req,
  output logic [ADDR_W-1:0] word_addr
);

  // counters run two slots ahead of the hs/vs/border outputs
  logic [$clog2(H_TOTAL)-1:0] h_cnt;
  logic [$clog2(V_TOTAL)-1:0] v_cnt;
  logic [ADDR_W-1:0]          next_addr;

  logic h_act;
  logic v_act;
  logic fetch;

  // lead stage is decoded in the same cycle as word_req
  logic hs_lead;
  logic vs_lead;
  logic border_lead;
  logic offset_lead;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_TOTAL - 1) begin
      h_cnt <= '0;
      if (v_cnt == V_TOTAL - 1)
        v_cnt <= '0; // next frame
      else
        v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign h_act = (h_cnt < H_ACTIVE);
  assign v_act = (v_cnt < V_ACTIVE);

  // one word covers an even pixel and the odd one after it
  assign fetch = h_act && v_act && !h_cnt[0];

  // fetch strobe and address
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      word_req  <= 1'b0;
      word_addr <= '0;
      next_addr <= '0;
    end else begin
      word_req <= fetch;
      if (fetch) begin
        word_addr <= next_addr;
        if (next_addr == ADDR_W'(WORDS_PER_FRAME - 1))
          next_addr <= '0;
        else
          next_addr <= next_addr + 1'b1;
      end
    end
  end

  // decode the counters one cycle early
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hs_lead     <= 1'b0;
      vs_lead     <= 1'b0;
      border_lead <= 1'b1; // nothing is active until the counters start
      offset_lead <= 1'b0;
    end else begin
      hs_lead     <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
      vs_lead     <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
      border_lead <= !(h_act && v_act);
      offset_lead <= h_cnt[0];
    end
  end

  // second stage lines up with the word arriving from the frame buffer
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hs     <= 1'b0;
      vs     <= 1'b0;
      border <= 1'b1;
      offset <= 1'b0;
    end else begin
      hs     <= hs_lead;
      vs     <= vs_lead;
      border <= border_lead;
      offset <= offset_lead;
    end
  end

endmodule

`default_nettype wire

//--- hw/dvi_pixel_select.sv
// picks one rgb pixel out of the fetched word and blanks it in the border
// pixel, de and syncs leave on the same edge

`timescale 1ns/1ps
`default_nettype none

module dvi_pixel_select import dvi_pkg::*; (
  input  wire               clock,
  input  wire               rst_n,
  input  wire [WORD_W-1:0]  word,
  input  wire               offset,
  input  wire               border,
  input  wire               hs,
  input  wire               vs,
  output logic [COLOR_W-1:0] red,
  output logic [COLOR_W-1:0] green,
  output logic [COLOR_W-1:0] blue,
  output logic              de,
  output logic              hs_q,
  output logic              vs_q
);

  logic [3*COLOR_W-1:0] pix;   // {red, green, blue}
  logic [3*COLOR_W-1:0] pix_bl;

  // first pixel in the low half, second pixel in the high half
  assign pix    = offset ? word[55:32] : word[23:0];
  assign pix_bl = border ? '0 : pix;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
      de    <= 1'b0;
      hs_q  <= 1'b0;
      vs_q  <= 1'b0;
    end else begin
      red   <= pix_bl[3*COLOR_W-1:2*COLOR_W];
      green <= pix_bl[2*COLOR_W-1:COLOR_W];
      blue  <= pix_bl[COLOR_W-1:0];
      de    <= !border;
      hs_q  <= hs;
      vs_q  <= vs;
    end
  end

endmodule

`default_nettype wire

//--- hw/dvi_ddr_out.sv
// dual data rate output stage for the 12-pin dvi bus and its clock pair
// behavioral model of per-pin ODDR cells, both phases are captured on the rising edge

`timescale 1ns/1ps
`default_nettype none

module dvi_ddr_out import dvi_pkg::*; (
  input  wire                clock,
  input  wire                rst_n,
  input  wire [COLOR_W-1:0]  red,
  input  wire [COLOR_W-1:0]  green,
  input  wire [COLOR_W-1:0]  blue,
  input  wire                de,
  input  wire                hs,
  input  wire                vs,
  output logic               dvi_xclk_p,
  output logic               dvi_xclk_n,
  output logic               dvi_de,
  output logic               dvi_h,
  output logic               dvi_v,
  output logic [PIN_W-1:0]   dvi_d
);

  logic [PIN_W-1:0] d_rise; // driven while clock is high
  logic [PIN_W-1:0] d_fall; // driven in the low phase after it
  logic             clk_en;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      d_rise <= '0;
      d_fall <= '0;
      dvi_de <= 1'b0;
      dvi_h  <= 1'b0;
      dvi_v  <= 1'b0;
    end else begin
      // high phase carries green and the red upper nibble
      d_rise <= {red[7:4], green[3:0], green[7:4]};
      // low phase carries the red lower nibble and blue
      d_fall <= {blue[3:0], blue[7:4], red[3:0]};
      dvi_de <= de; // same level in both phases
      dvi_h  <= hs;
      dvi_v  <= vs;
    end
  end

  // output mux of the ddr cell
  assign dvi_d = clock ? d_rise : d_fall;

  // enable taken on the falling edge so the pair starts on a full pulse
  always_ff @(negedge clock or negedge rst_n) begin
    if (!rst_n)
      clk_en <= 1'b0;
    else
      clk_en <= 1'b1;
  end

  assign dvi_xclk_p = clk_en & clock;
  assign dvi_xclk_n = clk_en & ~clock;

endmodule

`default_nettype wire

//--- hw/dvi_out_top.sv
// dvi output stage top, connects the timing controller to the pixel and ddr datapath
// the frame buffer answers word_req with the addressed word on the next rising edge

`timescale 1ns/1ps
`default_nettype none

module dvi_out_top import dvi_pkg::*; (
  input  wire               clock,
  input  wire               rst_n,
  input  wire [WORD_W-1:0]  word,
  output logic              word_req,
  output logic [ADDR_W-1:0] word_addr,
  output logic              dvi_xclk_p,
  output logic              dvi_xclk_n,
  output logic              dvi_de,
  output logic              dvi_h,
  output logic              dvi_v,
  output logic [PIN_W-1:0]  dvi_d
);

  // controller to pixel select
  logic hs;
  logic vs;
  logic border;
  logic offset;

  // pixel select to ddr stage
  logic [COLOR_W-1:0] red;
  logic [COLOR_W-1:0] green;
  logic [COLOR_W-1:0] blue;
  logic               de;
  logic               hs_q;
  logic               vs_q;

  dvi_timing_ctrl u_timing (
    .clock     (clock),
    .rst_n     (rst_n),
    .hs        (hs),
    .vs        (vs),
    .border    (border),
    .offset    (offset),
    .word_req  (word_req),
    .word_addr (word_addr)
  );

  dvi_pixel_select u_pixel (
    .clock  (clock),
    .rst_n  (rst_n),
    .word   (word),
    .offset (offset),
    .border (border),
    .hs     (hs),
    .vs     (vs),
    .red    (red),
    .green  (green),
    .blue   (blue),
    .de     (de),
    .hs_q   (hs_q),
    .vs_q   (vs_q)
  );

  dvi_ddr_out u_ddr (
    .clock      (clock),
    .rst_n      (rst_n),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .de         (de),
    .hs         (hs_q),
    .vs         (vs_q),
    .dvi_xclk_p (dvi_xclk_p),
    .dvi_xclk_n (dvi_xclk_n),
    .dvi_de     (dvi_de),
    .dvi_h      (dvi_h),
    .dvi_v      (dvi_v),
    .dvi_d      (dvi_d)
  );

endmodule

`default_nettype wire

//--- test/dvi_out_chk.sv
// concurrent checks on the dvi output stage, bound into dvi_out_top
// covers the clock pair, the fetch strobe and blanking of the data pins

`timescale 1ns/1ps
`default_nettype none

module dvi_out_chk import dvi_pkg::*; (
  input wire             clock,
  input wire             rst_n,
  input wire             word_req,
  input wire             dvi_xclk_p,
  input wire             dvi_xclk_n,
  input wire             dvi_de,
  input wire [PIN_W-1:0] dvi_d
);

  // pair starts one falling edge after reset release, both clock levels are looked at
  a_pair_low: assert property (@(posedge clock) disable iff (!rst_n)
    $past(rst_n) |-> (dvi_xclk_n == !dvi_xclk_p))
    else $error("xclk_n is not the inverse of xclk_p in the low phase");

  a_pair_high: assert property (@(negedge clock) disable iff (!rst_n)
    $past(rst_n) |-> (dvi_xclk_n == !dvi_xclk_p))
    else $error("xclk_n is not the inverse of xclk_p in the high phase");

  a_req_strobe: assert property (@(posedge clock) disable iff (!rst_n)
    word_req |=> !word_req)
    else $error("word_req held high for two cycles");

  // both phases of the ddr mux
  a_blank_low: assert property (@(posedge clock) disable iff (!rst_n)
    !dvi_de |-> (dvi_d == '0))
    else $error("dvi_d not zero in low phase while de is low");

  a_blank_high: assert property (@(negedge clock) disable iff (!rst_n)
    !dvi_de |-> (dvi_d == '0))
    else $error("dvi_d not zero in high phase while de is low");

endmodule

bind dvi_out_top dvi_out_chk u_chk (
  .clock      (clock),
  .rst_n      (rst_n),
  .word_req   (word_req),
  .dvi_xclk_p (dvi_xclk_p),
  .dvi_xclk_n (dvi_xclk_n),
  .dvi_de     (dvi_de),
  .dvi_d      (dvi_d)
);

`default_nettype wire

//--- test/dvi_out_tb.sv
// testbench for the dvi output stage that plays the frame buffer from a word table
// and checks both pin phases against a slot model over two frames

`timescale 1ns/1ps
`default_nettype none

module dvi_out_tb import dvi_pkg::*; ();

  localparam logic [31:0] SEED        = 32'h53ac_7807;
  localparam int          FRAME_SLOTS = H_TOTAL * V_TOTAL;
  localparam int          PIN_LAT     = 4;  // slot s shows on the pins after rising edge s+4
  localparam int          REQ_TIMEOUT = 4 * H_TOTAL;
  localparam int          RST_TIMEOUT = 50;

  logic              clock;
  logic              rst_n;
  logic [WORD_W-1:0] word;
  logic              word_req;
  logic [ADDR_W-1:0] word_addr;
  logic              dvi_xclk_p;
  logic              dvi_xclk_n;
  logic              dvi_de;
  logic              dvi_h;
  logic              dvi_v;
  logic [PIN_W-1:0]  dvi_d;

  logic [WORD_W-1:0] fb_table [WORDS_PER_FRAME];
  logic              req_pend;
  logic [ADDR_W-1:0] pend_addr;

  int pin_errs;
  int level_errs;
  int addr_errs;
  int count_errs;
  int other_errs;

  dvi_out_top dut (
    .clock      (clock),
    .rst_n      (rst_n),
    .word       (word),
    .word_req   (word_req),
    .word_addr  (word_addr),
    .dvi_xclk_p (dvi_xclk_p),
    .dvi_xclk_n (dvi_xclk_n),
    .dvi_de     (dvi_de),
    .dvi_h      (dvi_h),
    .dvi_v      (dvi_v),
    .dvi_d      (dvi_d)
  );

  always #10 clock = ~clock;

  // frame buffer answers each strobe one falling edge after it samples it
  always @(negedge clock) begin
    if (req_pend)
      word <= fb_table[pend_addr];
    req_pend  <= word_req;
    pend_addr <= word_addr;
  end

  function automatic bit slot_active(input int s);
    if (s < 0)
      return 1'b0;
    return ((s % H_TOTAL) < H_ACTIVE) && (((s / H_TOTAL) % V_TOTAL) < V_ACTIVE);
  endfunction

  function automatic bit slot_hs(input int s);
    return (s >= 0) && ((s % H_TOTAL) >= H_ACTIVE + H_FP)
      && ((s % H_TOTAL) < H_ACTIVE + H_FP + H_SYNC);
  endfunction

  function automatic bit slot_vs(input int s);
    int line;
    line = (s / H_TOTAL) % V_TOTAL;
    return (s >= 0) && (line >= V_ACTIVE + V_FP) && (line < V_ACTIVE + V_FP + V_SYNC);
  endfunction

  // rgb of a slot is black outside the active area
  function automatic logic [23:0] slot_pixel(input int s);
    int                h;
    int                line;
    logic [WORD_W-1:0] w;
    if (!slot_active(s))
      return '0;
    h    = s % H_TOTAL;
    line = (s / H_TOTAL) % V_TOTAL;
    w    = fb_table[line * (H_ACTIVE / 2) + h / 2];
    return (h % 2 == 1) ? w[55:32] : w[23:0];
  endfunction

  function automatic logic [PIN_W-1:0] rise_bits(input logic [23:0] pix);
    logic [7:0] red;
    logic [7:0] green;
    red   = pix[23:16];
    green = pix[15:8];
    return {red[7:4], green[3:0], green[7:4]};
  endfunction

  function automatic logic [PIN_W-1:0] fall_bits(input logic [23:0] pix);
    logic [7:0] red;
    logic [7:0] blue;
    red  = pix[23:16];
    blue = pix[7:0];
    return {blue[3:0], blue[7:4], red[3:0]};
  endfunction

  task automatic check_pins(input string name, input logic [PIN_W-1:0] exp,
                            input logic [PIN_W-1:0] act);
    if (act !== exp) begin
      pin_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      level_errs++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      addr_errs++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errs++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_all_low(input string tag);
    check_pins({tag, " dvi_d"}, '0, dvi_d);
    check_level({tag, " dvi_de"}, 1'b0, dvi_de);
    check_level({tag, " dvi_h"}, 1'b0, dvi_h);
    check_level({tag, " dvi_v"}, 1'b0, dvi_v);
    check_level({tag, " word_req"}, 1'b0, word_req);
    check_level({tag, " xclk_p"}, 1'b0, dvi_xclk_p);
    check_level({tag, " xclk_n"}, 1'b0, dvi_xclk_n);
  endtask

  task automatic wait_reset_release(output bit timed_out);
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
      #1;
      n++;
    end
    timed_out = (rst_n !== 1'b1);
  endtask

  // returns in the high phase of the cycle that carries the first strobe
  task automatic wait_word_req(output int cycles, output bit timed_out);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < REQ_TIMEOUT) begin
      @(posedge clock);
      #5;
      cycles++;
      seen = (word_req === 1'b1);
    end
    timed_out = !seen;
  endtask

  task automatic run_frames(input int first);
    int               m;
    int               ps;  // slot on the pins
    int               rs;  // slot on the counters
    int               h_run;
    int               v_run;
    int               h_pulses;
    int               v_pulses;
    int               line_reqs;
    int               fetches;
    int               last_h_rise;
    int               last_de_fall;
    logic             prev_h;
    logic             prev_v;
    logic             prev_de;
    logic             req_exp;
    logic [ADDR_W-1:0] exp_addr;
    logic [23:0]      pix;
    h_run = 0;
    v_run = 0;
    h_pulses = 0;
    v_pulses = 0;
    line_reqs = 0;
    fetches = 0;
    last_h_rise = -1;
    last_de_fall = -1000;
    prev_h = 1'b0;
    prev_v = 1'b0;
    prev_de = 1'b0;
    exp_addr = '0;
    for (m = first; m < PIN_LAT + 2 * FRAME_SLOTS; m++) begin
      ps  = m - PIN_LAT;
      rs  = m - 1;
      pix = slot_pixel(ps);
      check_pins($sformatf("slot %0d high dvi_d", ps), rise_bits(pix), dvi_d);
      check_level($sformatf("slot %0d high de", ps), slot_active(ps), dvi_de);
      check_level($sformatf("slot %0d high hs", ps), slot_hs(ps), dvi_h);
      check_level($sformatf("slot %0d high vs", ps), slot_vs(ps), dvi_v);
      check_level($sformatf("cycle %0d xclk_p", m), m >= 2, dvi_xclk_p);
      check_level($sformatf("cycle %0d xclk_n", m), 1'b0, dvi_xclk_n);
      req_exp = slot_active(rs) && (rs % 2 == 0);
      check_level($sformatf("slot %0d word_req", rs), req_exp, word_req);
      if (req_exp) begin
        check_addr($sformatf("slot %0d word_addr", rs), exp_addr, word_addr);
        exp_addr++;  // wraps with the frame
      end
      if (word_req === 1'b1) begin
        line_reqs++;
        if (rs < 2 * FRAME_SLOTS)
          fetches++;
      end
      if (rs % H_TOTAL == H_TOTAL - 1) begin
        check_count($sformatf("requests in line %0d", rs / H_TOTAL),
                    ((rs / H_TOTAL) % V_TOTAL < V_ACTIVE) ? H_ACTIVE / 2 : 0, line_reqs);
        line_reqs = 0;
      end
      // sync widths and spacing from edges on the pins
      if (dvi_de !== 1'b1 && prev_de === 1'b1)
        last_de_fall = m;
      if (dvi_h === 1'b1 && prev_h !== 1'b1) begin
        h_pulses++;
        if (last_h_rise >= 0)
          check_count("hsync period", H_TOTAL, m - last_h_rise);
        if (m - last_de_fall < H_TOTAL)
          check_count("hsync after de", H_FP, m - last_de_fall);
        last_h_rise = m;
      end
      if (dvi_h === 1'b1) begin
        h_run++;
      end else if (h_run > 0) begin
        check_count("hsync width", H_SYNC, h_run);
        h_run = 0;
      end
      if (dvi_v === 1'b1 && prev_v !== 1'b1)
        v_pulses++;
      if (dvi_v === 1'b1) begin
        v_run++;
      end else if (v_run > 0) begin
        check_count("vsync width in cycles", V_SYNC * H_TOTAL, v_run);
        v_run = 0;
      end
      prev_h  = dvi_h;
      prev_v  = dvi_v;
      prev_de = dvi_de;
      @(negedge clock);
      #5;
      check_pins($sformatf("slot %0d low dvi_d", ps), fall_bits(pix), dvi_d);
      check_level($sformatf("slot %0d low de", ps), slot_active(ps), dvi_de);
      check_level($sformatf("slot %0d low hs", ps), slot_hs(ps), dvi_h);
      check_level($sformatf("slot %0d low vs", ps), slot_vs(ps), dvi_v);
      check_level($sformatf("cycle %0d low xclk_p", m), 1'b0, dvi_xclk_p);
      check_level($sformatf("cycle %0d low xclk_n", m), 1'b1, dvi_xclk_n);
      @(posedge clock);
      #5;
    end
    check_count("hsync pulses", 2 * V_TOTAL, h_pulses);
    check_count("vsync pulses", 2, v_pulses);
    check_count("fetches in two frames", 2 * WORDS_PER_FRAME, fetches);
  endtask

  task automatic finish_run();
    int total;
    total = pin_errs + level_errs + addr_errs + count_errs + other_errs;
    $display("errors: pins %0d, levels %0d, addr %0d, counts %0d, other %0d",
             pin_errs, level_errs, addr_errs, count_errs, other_errs);
    if (total == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  initial begin
    int          i;
    int          first;
    bit          timed_out;
    logic [31:0] hi;
    logic [31:0] lo;
    clock      = 1'b0;
    rst_n      = 1'b0;
    word       = 64'h5a5a_a5a5_3c3c_c3c3;  // nonzero before the first fetch
    req_pend   = 1'b0;
    pend_addr  = '0;
    pin_errs   = 0;
    level_errs = 0;
    addr_errs  = 0;
    count_errs = 0;
    other_errs = 0;
    hi = $urandom(SEED);
    fb_table[0] = {WORD_W{1'b1}};
    fb_table[1] = 64'h0f0f_0f0f_0f0f_0f0f;
    for (i = 2; i < WORDS_PER_FRAME; i++) begin
      hi = $urandom;
      lo = $urandom;
      fb_table[i] = {hi, lo};
    end
    for (i = 0; i < 16; i++) begin
      @(posedge clock);
      #5;
      check_all_low($sformatf("reset cycle %0d", i));
    end
    @(negedge clock);
    rst_n <= 1'b1;
    wait_reset_release(timed_out);
    if (timed_out) begin
      other_errs++;
      $display("reset was not released within %0d ns", RST_TIMEOUT);
      finish_run();
    end else begin
      #4;
      check_all_low("after reset");
      wait_word_req(first, timed_out);
      if (timed_out) begin
        other_errs++;
        $display("no word_req within %0d cycles after reset", REQ_TIMEOUT);
        finish_run();
      end else begin
        if (first != 1) begin
          other_errs++;
          $display("first word_req came %0d cycles after reset instead of 1", first);
        end
        run_frames(first);
        finish_run();
      end
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/dvi_pkg.sv
hw/dvi_timing_ctrl.sv
hw/dvi_pixel_select.sv
hw/dvi_ddr_out.sv
hw/dvi_out_top.sv
test/dvi_out_chk.sv
test/dvi_out_tb.sv
